//--- include/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// physical address split: | tag 31..10 | index 9..4 | offset 3..0 |
`define ADDR_W    32
`define OFFSET_W  4
`define INDEX_W   6
`define TAG_W     22

// geometry
`define SETS      64
`define WAYS      2

// data paths
`define DATA_W    64   // bus beat and fetch word
`define LINE_W    128  // two words per line
`define BEATS     2    // beats per line fill

`endif

//--- design/icache_pkg.sv
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  // cache controller states
  typedef enum logic [2:0] {
    IDLE,    // ready for a fetch
    LOOKUP,  // tag compare on the registered address
    HIT,     // data read and response
    REQ,     // burst address on the bus
    FILL     // collecting beats
  } cache_state_e;

  // who holds the shared read bus
  typedef enum logic [1:0] {
    NONE,
    PORT0,
    PORT1
  } arb_owner_e;

  // address fields
  typedef logic [`TAG_W-1:0]   tag_t;
  typedef logic [`INDEX_W-1:0] index_t;

endpackage

`default_nettype wire

//--- design/mem_rd_if.sv
`default_nettype none

`include "icache_consts.svh"

// burst read channel between one cache and the arbiter
interface mem_rd_if;
  logic                ar_valid;
  logic                ar_ready;
  logic [`ADDR_W-1:0]  ar_addr;   // line aligned
  logic                r_valid;
  logic                r_ready;
  logic [`DATA_W-1:0]  r_data;
  logic                r_last;    // second beat of the line

  modport master (
    output ar_valid, ar_addr, r_ready,
    input  ar_ready, r_valid, r_data, r_last
  );

  modport slave (
    input  ar_valid, ar_addr, r_ready,
    output ar_ready, r_valid, r_data, r_last
  );
endinterface

`default_nettype wire

//--- design/icache_tag_store.sv
`default_nettype none

`include "icache_consts.svh"

module icache_tag_store (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               flush_i,
  input  wire logic               lookup_i,
  input  wire icache_pkg::index_t index_i,
  input  wire icache_pkg::tag_t   tag_i,
  output logic                    hit_o,
  output logic                    hit_way_o,
  output logic                    victim_way_o,
  input  wire logic               fill_i,
  input  wire logic               fill_way_i,
  input  wire icache_pkg::tag_t   fill_tag_i,
  input  wire logic               touch_i
);
  import icache_pkg::*;

  tag_t             tags_q  [`WAYS][`SETS];
  logic [`SETS-1:0] valid_q [`WAYS];
  logic [`SETS-1:0] lru_q;      // per set, the way to replace next

  index_t           index_q;    // set under lookup, also used by fill and touch
  tag_t             look_tag_q;
  logic [`WAYS-1:0] way_hit;

  // latch the request address when the cache accepts it
  always_ff @(posedge clk) begin
    if (lookup_i) begin
      index_q    <= index_i;
      look_tag_q <= tag_i;
    end
  end

  always_comb begin
    for (int w = 0; w < `WAYS; w++) begin
      way_hit[w] = valid_q[w][index_q] && (tags_q[w][index_q] == look_tag_q);
    end
  end

  assign hit_o        = |way_hit;
  assign hit_way_o    = way_hit[1];      // way 0 unless way 1 matches
  assign victim_way_o = lru_q[index_q];

  always_ff @(posedge clk) begin
    if (fill_i) begin
      tags_q[fill_way_i][index_q] <= fill_tag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < `WAYS; w++) begin
        valid_q[w] <= '0;
      end
      lru_q <= '0;
    end else begin
      if (flush_i) begin
        for (int w = 0; w < `WAYS; w++) begin
          valid_q[w] <= '0;  // fence.i style invalidate
        end
      end
      if (fill_i) begin
        valid_q[fill_way_i][index_q] <= 1'b1;
        lru_q[index_q]               <= ~fill_way_i;
      end else if (touch_i) begin
        lru_q[index_q] <= ~hit_way_o;  // other way becomes the victim
      end
    end
  end

endmodule

`default_nettype wire

//--- design/icache_data_store.sv
`default_nettype none

`include "icache_consts.svh"

module icache_data_store (
  input  wire logic               clk,
  input  wire logic               rd_i,
  input  wire icache_pkg::index_t index_i,
  input  wire logic               way_i,
  input  wire logic               word_sel_i,
  output logic [`DATA_W-1:0]      rdata_o,
  input  wire logic               wr_i,
  input  wire logic               wr_half_i,
  input  wire logic [`DATA_W-1:0] wdata_i
);

  // one 64 x 128 array per way
  logic [`LINE_W-1:0] line_q [`WAYS][`SETS];

  always_ff @(posedge clk) begin
    if (wr_i) begin
      line_q[way_i][index_i][wr_half_i*`DATA_W +: `DATA_W] <= wdata_i;  // half line per beat
    end
  end

  // registered read port, output holds between reads
  always_ff @(posedge clk) begin
    if (rd_i) begin
      rdata_o <= line_q[way_i][index_i][word_sel_i*`DATA_W +: `DATA_W];
    end
  end

endmodule

`default_nettype wire

//--- design/icache.sv
`default_nettype none

`include "icache_consts.svh"

module icache (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               flush_i,
  input  wire logic               fetch_valid_i,
  output logic                    fetch_ready_o,
  input  wire logic [`ADDR_W-1:0] fetch_addr_i,
  output logic                    rsp_valid_o,
  input  wire logic               rsp_ready_i,
  output logic [`DATA_W-1:0]      rsp_data_o,
  mem_rd_if.master                mem
);
  import icache_pkg::*;

  cache_state_e              state_q;
  cache_state_e              state_d;
  logic [`ADDR_W-1:0]        addr_q;
  logic                      way_q;   // hit way or chosen victim
  logic [$clog2(`BEATS)-1:0] beat_q;  // which half the next beat fills
  logic                      ready_q;
  logic                      rsp_valid_q;

  logic   accept;
  logic   hit;
  logic   hit_way;
  logic   victim_way;
  logic   ar_fire;
  logic   beat_fire;
  logic   fill;
  logic   touch;
  logic   rd;
  index_t index;
  tag_t   tag;

  assign index = addr_q[`OFFSET_W +: `INDEX_W];
  assign tag   = addr_q[`ADDR_W-1 -: `TAG_W];

  assign accept    = fetch_valid_i & ready_q;
  assign ar_fire   = mem.ar_valid & mem.ar_ready;
  assign beat_fire = mem.r_valid & mem.r_ready;
  assign fill      = beat_fire & mem.r_last;
  assign touch     = (state_q == LOOKUP) & hit;
  assign rd        = (state_q == HIT) & ~rsp_valid_q;  // one read per response

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: state_d = hit ? HIT : REQ;
      REQ: begin
        if (ar_fire) begin
          state_d = FILL;
        end
      end
      FILL: begin
        if (fill) begin
          state_d = HIT;  // answer from the array once the line is in
        end
      end
      HIT: begin
        if (rsp_valid_q && rsp_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      ready_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
      beat_q      <= '0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == IDLE);
      if (rd) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_valid_q && rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      if (state_q == REQ) begin
        beat_q <= '0;
      end else if (beat_fire) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
    if (state_q == LOOKUP) begin
      way_q <= hit ? hit_way : victim_way;
    end
  end

  assign fetch_ready_o = ready_q;
  assign rsp_valid_o   = rsp_valid_q;

  assign mem.ar_valid = (state_q == REQ);
  assign mem.ar_addr  = {addr_q[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
  assign mem.r_ready  = (state_q == FILL);

  icache_tag_store tag_store_inst (
    .clk          (clk),
    .rst          (rst),
    .flush_i      (flush_i & (state_q == IDLE)),  // flush waits for an idle cache
    .lookup_i     (accept),
    .index_i      (fetch_addr_i[`OFFSET_W +: `INDEX_W]),
    .tag_i        (fetch_addr_i[`ADDR_W-1 -: `TAG_W]),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way),
    .fill_i       (fill),
    .fill_way_i   (way_q),
    .fill_tag_i   (tag),
    .touch_i      (touch)
  );

  icache_data_store data_store_inst (
    .clk        (clk),
    .rd_i       (rd),
    .index_i    (index),
    .way_i      (way_q),
    .word_sel_i (addr_q[`OFFSET_W-1]),  // bit 3 picks the word
    .rdata_o    (rsp_data_o),
    .wr_i       (beat_fire),
    .wr_half_i  (beat_q),
    .wdata_i    (mem.r_data)
  );

endmodule

`default_nettype wire

//--- design/bus_arbiter.sv
`default_nettype none

`include "icache_consts.svh"

module bus_arbiter (
  input  wire logic               clk,
  input  wire logic               rst,
  mem_rd_if.slave                 m0,
  mem_rd_if.slave                 m1,
  output logic                    mem_ar_valid_o,
  input  wire logic               mem_ar_ready_i,
  output logic [`ADDR_W-1:0]      mem_ar_addr_o,
  input  wire logic               mem_r_valid_i,
  output logic                    mem_r_ready_o,
  input  wire logic [`DATA_W-1:0] mem_r_data_i,
  input  wire logic               mem_r_last_i
);
  import icache_pkg::*;

  arb_owner_e owner_q;
  logic       last_q;      // 1 when port 1 had the last burst
  logic       own0;
  logic       own1;
  logic       burst_done;

  assign own0       = (owner_q == PORT0);
  assign own1       = (owner_q == PORT1);
  assign burst_done = mem_r_valid_i & mem_r_ready_o & mem_r_last_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      owner_q <= NONE;
      last_q  <= 1'b1;  // port 0 wins the first tie
    end else begin
      case (owner_q)
        NONE: begin
          if (m0.ar_valid && m1.ar_valid) begin
            owner_q <= last_q ? PORT0 : PORT1;
          end else if (m0.ar_valid) begin
            owner_q <= PORT0;
          end else if (m1.ar_valid) begin
            owner_q <= PORT1;
          end
        end
        default: begin
          // hold the bus until the last beat is taken
          if (burst_done) begin
            owner_q <= NONE;
            last_q  <= own1;
          end
        end
      endcase
    end
  end

  // address channel to the owner only
  assign mem_ar_valid_o = (own0 & m0.ar_valid) | (own1 & m1.ar_valid);
  assign mem_ar_addr_o  = own1 ? m1.ar_addr : m0.ar_addr;
  assign m0.ar_ready    = own0 & mem_ar_ready_i;
  assign m1.ar_ready    = own1 & mem_ar_ready_i;

  // read channel
  assign mem_r_ready_o = (own0 & m0.r_ready) | (own1 & m1.r_ready);
  assign m0.r_valid    = own0 & mem_r_valid_i;
  assign m1.r_valid    = own1 & mem_r_valid_i;
  assign m0.r_data     = mem_r_data_i;  // qualified by r_valid
  assign m1.r_data     = mem_r_data_i;
  assign m0.r_last     = mem_r_last_i;
  assign m1.r_last     = mem_r_last_i;

endmodule

`default_nettype wire

//--- design/fetch_subsystem.sv
`default_nettype none

`include "icache_consts.svh"

module fetch_subsystem (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               flush_i,
  // fetch port 0
  input  wire logic               fetch0_valid_i,
  output logic                    fetch0_ready_o,
  input  wire logic [`ADDR_W-1:0] fetch0_addr_i,
  output logic                    fetch0_rsp_valid_o,
  input  wire logic               fetch0_rsp_ready_i,
  output logic [`DATA_W-1:0]      fetch0_rsp_data_o,
  // fetch port 1
  input  wire logic               fetch1_valid_i,
  output logic                    fetch1_ready_o,
  input  wire logic [`ADDR_W-1:0] fetch1_addr_i,
  output logic                    fetch1_rsp_valid_o,
  input  wire logic               fetch1_rsp_ready_i,
  output logic [`DATA_W-1:0]      fetch1_rsp_data_o,
  // shared memory read bus
  output logic                    mem_ar_valid_o,
  input  wire logic               mem_ar_ready_i,
  output logic [`ADDR_W-1:0]      mem_ar_addr_o,
  input  wire logic               mem_r_valid_i,
  output logic                    mem_r_ready_o,
  input  wire logic [`DATA_W-1:0] mem_r_data_i,
  input  wire logic               mem_r_last_i
);

  mem_rd_if bus0 ();
  mem_rd_if bus1 ();

  icache icache0_inst (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch0_valid_i),
    .fetch_ready_o (fetch0_ready_o),
    .fetch_addr_i  (fetch0_addr_i),
    .rsp_valid_o   (fetch0_rsp_valid_o),
    .rsp_ready_i   (fetch0_rsp_ready_i),
    .rsp_data_o    (fetch0_rsp_data_o),
    .mem           (bus0.master)
  );

  icache icache1_inst (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch1_valid_i),
    .fetch_ready_o (fetch1_ready_o),
    .fetch_addr_i  (fetch1_addr_i),
    .rsp_valid_o   (fetch1_rsp_valid_o),
    .rsp_ready_i   (fetch1_rsp_ready_i),
    .rsp_data_o    (fetch1_rsp_data_o),
    .mem           (bus1.master)
  );

  bus_arbiter arbiter_inst (
    .clk            (clk),
    .rst            (rst),
    .m0             (bus0.slave),
    .m1             (bus1.slave),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .mem_r_data_i   (mem_r_data_i),
    .mem_r_last_i   (mem_r_last_i)
  );

endmodule

`default_nettype wire

//--- test/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
  parameter int HALF_PERIOD = 5,
  parameter int RST_CYCLES  = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;  // released on an edge like any other input
  end

endmodule

`default_nettype wire

//--- test/tb_fetch_subsystem.sv
`default_nettype none

`include "icache_consts.svh"

module tb_fetch_subsystem;
  localparam int N_RAND      = 100;
  localparam int N_DUAL      = 60;
  localparam int MISS_CYCLES = 50;  // generous bound for one miss with random bus gaps
  localparam int LIMIT       = (2 * N_RAND + 2 * N_DUAL + 20) * MISS_CYCLES + 500;

  logic               clk;
  logic               rst;
  logic               flush;
  logic               valid [2];
  logic [`ADDR_W-1:0] addr [2];
  logic               ready [2];
  logic               rsp_valid [2];
  logic               rsp_ready [2];
  logic [`DATA_W-1:0] rsp_data [2];
  logic               ar_valid;
  logic               ar_ready = 1'b0;
  logic [`ADDR_W-1:0] ar_addr;
  logic               r_valid = 1'b0;
  logic               r_ready;
  logic               r_last = 1'b0;
  logic [`DATA_W-1:0] r_data = '0;

  integer seed = 97;
  int     errors;
  int     cycles;
  int     ar_count;
  int     exp_bursts;
  bit     burst_open;

  // reference cache state per port
  logic [`TAG_W-1:0] m_tag [2][2][64];
  bit                m_valid [2][2][64];
  bit                m_lru [2][64];

  // memory model state
  bit          mem_busy;
  logic [31:0] mem_base;
  int          mem_beat;
  logic [31:0] rnd_m;

  tb_clkgen clkgen_inst (.clk_o(clk), .rst_o(rst));

  fetch_subsystem fetch_subsystem_inst (
    .clk (clk), .rst (rst), .flush_i (flush),
    .fetch0_valid_i (valid[0]), .fetch0_ready_o (ready[0]), .fetch0_addr_i (addr[0]),
    .fetch0_rsp_valid_o (rsp_valid[0]), .fetch0_rsp_ready_i (rsp_ready[0]),
    .fetch0_rsp_data_o (rsp_data[0]),
    .fetch1_valid_i (valid[1]), .fetch1_ready_o (ready[1]), .fetch1_addr_i (addr[1]),
    .fetch1_rsp_valid_o (rsp_valid[1]), .fetch1_rsp_ready_i (rsp_ready[1]),
    .fetch1_rsp_data_o (rsp_data[1]),
    .mem_ar_valid_o (ar_valid), .mem_ar_ready_i (ar_ready), .mem_ar_addr_o (ar_addr),
    .mem_r_valid_i (r_valid), .mem_r_ready_o (r_ready), .mem_r_data_i (r_data),
    .mem_r_last_i (r_last)
  );

  // content of the 64-bit word holding byte address a
  function automatic logic [63:0] mem_word(input logic [31:0] a);
    logic [63:0] w;
    w = {35'd0, a[31:3]};
    return w * 64'h9e37_79b9_7f4a_7c15 + w;
  endfunction

  // tag 0..3, set 0..3, either word, so sets conflict a lot
  function automatic logic [31:0] rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return {20'd0, r[1:0], 4'd0, r[3:2], r[4], 3'd0};
  endfunction

  // returns 1 on a predicted hit and updates the model like a real access
  function automatic bit model_access(input int p, input logic [31:0] a);
    logic [`TAG_W-1:0] t;
    int                s;
    bit                v;
    t = a[31:10];
    s = int'(a[9:4]);
    for (int w = 0; w < 2; w++) begin
      if (m_valid[p][w][s] && m_tag[p][w][s] == t) begin
        m_lru[p][s] = (w == 0);  // other way is next victim
        return 1'b1;
      end
    end
    v = m_lru[p][s];
    m_tag[p][v][s]   = t;
    m_valid[p][v][s] = 1'b1;
    m_lru[p][s]      = ~v;
    return 1'b0;
  endfunction

  function automatic void model_clear(input bit with_lru);
    for (int p = 0; p < 2; p++) begin
      for (int s = 0; s < 64; s++) begin
        m_valid[p][0][s] = 1'b0;
        m_valid[p][1][s] = 1'b0;
        if (with_lru) begin
          m_lru[p][s] = 1'b0;
        end
      end
    end
  endfunction

  // one full fetch on port p, checked against the model
  task automatic fetch(input int p, input logic [31:0] a, input bit bp, output bit hit);
    int          lat;
    logic [63:0] held;
    logic [63:0] exp;
    logic [31:0] r;
    @(negedge clk);
    while (!ready[p]) @(negedge clk);
    @(posedge clk);
    valid[p] <= 1'b1;
    addr[p]  <= a;
    @(posedge clk);  // accepted here
    valid[p] <= 1'b0;
    hit = model_access(p, a);
    if (!hit) begin
      exp_bursts++;
    end
    lat = 0;
    @(negedge clk);
    if (ready[p]) begin
      $display("port %0d accepts a second request with one in flight", p);
      errors++;
    end
    while (!rsp_valid[p]) begin
      @(negedge clk);
      lat++;
    end
    if (hit && lat != 2) begin
      $display("[FAIL] fetch%0d_rsp_valid_o latency 0x%0h expected 0x2", p, lat);
      errors++;
    end
    held = rsp_data[p];
    exp  = mem_word(a);
    if (held !== exp) begin
      $display("[FAIL] fetch%0d_rsp_data_o addr 0x%08h got 0x%016h expected 0x%016h",
               p, a, held, exp);
      errors++;
    end
    while (!rsp_ready[p]) begin
      @(posedge clk);
      r = $random(seed);
      rsp_ready[p] <= bp ? r[0] : 1'b1;
      @(negedge clk);
      if (!rsp_valid[p] || rsp_data[p] !== held) begin
        $display("port %0d response changed while it was held", p);
        errors++;
      end
    end
    @(posedge clk);  // response transfers
    r = $random(seed);
    rsp_ready[p] <= bp ? r[0] : 1'b1;
  endtask

  task automatic flush_all();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    model_clear(1'b0);
  endtask

  task automatic report(input string name, input int err_before);
    if (ar_count != exp_bursts) begin
      $display("[FAIL] mem_ar transfers 0x%0h expected 0x%0h", ar_count, exp_bursts);
      errors++;
    end
    $display("%s: %s", name, (errors == err_before) ? "ok" : "errors");
  endtask

  // external memory with random ready and random beat gaps
  always @(posedge clk) begin
    rnd_m = $random(seed);
    if (rst) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
      r_last   <= 1'b0;
      r_data   <= '0;
      mem_busy = 1'b0;
      mem_beat = 0;
    end else begin
      ar_ready <= (rnd_m[1:0] != 2'b00);  // also during a burst, so an early address shows
      if (!mem_busy) begin
        if (ar_valid && ar_ready) begin
          mem_busy = 1'b1;
          mem_base = ar_addr;
          mem_beat = 0;
        end
      end else begin
        if (r_valid && r_ready) begin
          mem_beat++;
        end
        if (!(r_valid && !r_ready)) begin  // a pending beat stays put
          if (mem_beat == `BEATS) begin
            mem_busy = 1'b0;
            r_valid  <= 1'b0;
          end else begin
            r_valid <= rnd_m[2] | rnd_m[3];
            r_data  <= mem_word(mem_base + 32'(mem_beat * 8));
            r_last  <= (mem_beat == `BEATS - 1);
          end
        end
      end
    end
  end

  // bursts must not overlap and must be line aligned
  always @(posedge clk) begin
    if (!rst) begin
      if (ar_valid && ar_ready) begin
        ar_count++;
        if (burst_open) begin
          $display("burst address at 0x%08h while another burst is open", ar_addr);
          errors++;
        end
        if (ar_addr[3:0] != 4'h0) begin
          $display("[FAIL] mem_ar_addr_o 0x%08h low bits 0x%0h expected 0x0",
                   ar_addr, ar_addr[3:0]);
          errors++;
        end
        burst_open = 1'b1;
      end
      if (r_valid && r_ready && r_last) begin
        burst_open = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout after %0d cycles, a fetch never completed", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    bit hit;
    bit hit0;
    bit hit1;
    int err0;
    bit exp_hit [6];
    logic [31:0] lru_seq [6];
    int bursts_before;
    exp_hit = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    lru_seq = '{32'h0450, 32'h0850, 32'h0450, 32'h0c50, 32'h0458, 32'h0850};  // A B A C A B
    flush = 1'b0;
    for (int p = 0; p < 2; p++) begin
      valid[p]     = 1'b0;
      addr[p]      = '0;
      rsp_ready[p] = 1'b1;
    end
    model_clear(1'b1);
    wait (!rst);

    err0 = errors;
    for (int i = 0; i < N_RAND; i++) fetch(0, rand_addr(), 1'b0, hit);
    report("random fetches on port 0", err0);

    err0 = errors;
    for (int i = 0; i < N_RAND; i++) fetch(1, rand_addr(), 1'b0, hit);
    report("random fetches on port 1", err0);

    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      bursts_before = ar_count;
      fetch(0, lru_seq[i], 1'b0, hit);
      if (ar_count - bursts_before != (exp_hit[i] ? 0 : 1)) begin
        $display("[FAIL] mem_ar transfers at LRU step %0d 0x%0h expected 0x%0h",
                 i, ar_count - bursts_before, !exp_hit[i]);
        errors++;
      end
    end
    report("LRU replacement in one set", err0);

    err0 = errors;
    flush_all();
    fetch(0, lru_seq[0], 1'b0, hit);
    fetch(0, lru_seq[1], 1'b0, hit);
    fetch(0, lru_seq[3], 1'b0, hit);
    fetch(1, rand_addr(), 1'b0, hit);
    report("refetch after flush", err0);

    err0 = errors;
    flush_all();
    fork
      begin
        for (int i = 0; i < N_DUAL; i++) fetch(0, rand_addr(), 1'b1, hit0);
      end
      begin
        for (int i = 0; i < N_DUAL; i++) fetch(1, rand_addr(), 1'b1, hit1);
      end
    join
    report("both ports with back-pressure", err0);

    $display("summary: %0d errors, %0d bursts, %0d cycles", errors, ar_count, cycles);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_subsystem.f
+incdir+include
design/icache_pkg.sv
design/mem_rd_if.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache.sv
design/bus_arbiter.sv
design/fetch_subsystem.sv
test/tb_clkgen.sv
test/tb_fetch_subsystem.sv

//--- Makefile
TOP = tb_fetch_subsystem

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 -f fetch_subsystem.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
